//--- common/edpPkg.sv
package edpPkg;

  // Data words, bit 0 is the most significant
  typedef logic [0:35] word36;
  typedef logic [0:17] half18;

  // Fast memory sizing
  localparam int fmAddrWidth = 4;
  localparam int fmWords = 1 << fmAddrWidth;

  // Adder A side operand
  typedef enum logic [0:1] {adaAR, adaARX, adaMQ, adaZero} adaSel_e;

  // Adder B side operand, doubled forms shift across into BRX/ARX
  typedef enum logic [0:1] {adbFM, adbBRx2, adbBR, adbARx4} adbSel_e;

  typedef enum logic [0:2] {
    fnAdd, fnSub, fnAnd, fnOr, fnXor, fnPassA, fnPassB, fnSetOnes
  } adFunc_e;

  // AR halves and ARX source
  typedef enum logic [0:2] {
    srcHold, srcCache, srcAD, srcADX, srcMQ, srcRotAR, srcAdShl, srcZero
  } arSel_e;

  // Universal shift register function for MQ
  typedef enum logic [0:1] {mqLoadAD, mqShl, mqShr, mqHold} mqFunc_e;

  // EBUS readout source, same encoding as the diag function field
  typedef enum logic [0:2] {dAR, dBR, dMQ, dFM, dBRX, dARX, dADX, dAD} diagFunc_e;

  typedef struct packed {
    adaSel_e ada;
    adbSel_e adb;
    adFunc_e adFunc;
    logic adLong;       // ADX carry out feeds AD
    logic cryIn;        // carry into ADX bit 35
    arSel_e arlSel;
    arSel_e arrSel;
    arSel_e arxSel;
    mqFunc_e mqFunc;
    logic brLoad;
    logic brxLoad;
    logic [0:fmAddrWidth-1] fmAdr;
    logic fmWriteL;
    logic fmWriteR;
    logic adToEbusL;
    logic adToEbusR;
  } ebMicro;

  typedef struct packed {
    word36 ad;
    word36 adx;
    logic [0:1] adEx;   // sign extension bits -2 and -1
    logic adCarry;
    logic adOverflow;
  } adResult;

  typedef struct packed {
    word36 ar;
    word36 arx;
    word36 br;
    word36 brx;
    word36 mq;
  } regFile;

endpackage

//--- edp/edpRegs.sv
`timescale 1ns/1ps

module edpRegs(
  input  logic CLK,
  input  logic reset,
  input  edpPkg::ebMicro micro,
  input  edpPkg::word36 cacheData,
  input  edpPkg::adResult ad,
  output edpPkg::regFile regs
);
  import edpPkg::*;

  // AR rotated left by one stands in for the shifter
  word36 rotAR;

  word36 arlSrc;
  word36 arrSrc;
  word36 arxSrc;
  half18 arlNext;
  half18 arrNext;
  word36 mqNext;

  // Shared source mux for AR halves and ARX
  function automatic word36 pickSource(
    input arSel_e sel,
    input word36 hold,
    input word36 cache,
    input adResult adr,
    input word36 mq,
    input word36 rot
  );
    word36 shl;
    // AD doubled, ADX bit 0 comes in at the bottom
    shl = {adr.ad[1:35], adr.adx[0]};
    case (sel)
      srcHold:   pickSource = hold;
      srcCache:  pickSource = cache;
      srcAD:     pickSource = adr.ad;
      srcADX:    pickSource = adr.adx;
      srcMQ:     pickSource = mq;
      srcRotAR:  pickSource = rot;
      srcAdShl:  pickSource = shl;
      default:   pickSource = '0;
    endcase
  endfunction

  assign rotAR = {regs.ar[1:35], regs.ar[0]};

  // AR left and right halves steer independently
  always_comb begin
    arlSrc = pickSource(micro.arlSel, regs.ar, cacheData, ad, regs.mq, rotAR);
    arrSrc = pickSource(micro.arrSel, regs.ar, cacheData, ad, regs.mq, rotAR);
    arlNext = arlSrc[0:17];
    arrNext = arrSrc[18:35];
  end

  // ARX takes a whole word, rotated AR gives the AR to ARX path
  always_comb begin
    arxSrc = pickSource(micro.arxSel, regs.arx, cacheData, ad, regs.mq, rotAR);
  end

  // MQ next state
  always_comb begin
    case (micro.mqFunc)
      mqLoadAD: mqNext = ad.ad;
      mqShl:    mqNext = {regs.mq[1:35], ad.adCarry};
      // Right shift refills the top with old bit 1
      mqShr:    mqNext = {regs.mq[1], regs.mq[0:34]};
      default:  mqNext = regs.mq;
    endcase
  end

  // All registers sample pre-edge values
  always_ff @(posedge CLK) begin
    if (reset) begin
      regs <= '0;
    end else begin
      regs.ar <= {arlNext, arrNext};
      regs.arx <= arxSrc;
      regs.mq <= mqNext;

      // BR and BRX see the old AR and ARX
      if (micro.brLoad) begin
        regs.br <= regs.ar;
      end
      if (micro.brxLoad) begin
        regs.brx <= regs.arx;
      end
    end
  end

endmodule

//--- edp/edpAdder.sv
`timescale 1ns/1ps

module edpAdder(
  input  edpPkg::ebMicro micro,
  input  edpPkg::regFile regs,
  input  edpPkg::word36 fmData,
  output edpPkg::adResult result
);
  import edpPkg::*;

  // AD side operands carry two extension bits, -2 and -1
  logic [0:37] adaOp;
  logic [0:37] adbOp;
  logic [0:37] adbEff;
  word36 adxaOp;
  word36 adxbOp;
  word36 adxbEff;

  logic subtract;
  logic arith;
  logic adxCin;
  logic adCin;
  logic [0:36] adxSum;
  logic [0:37] adSum;
  logic [0:36] adLow;
  logic [0:37] adFull;
  word36 adxFull;
  logic carryOut;

  // ADA mux
  always_comb begin
    case (micro.ada)
      adaAR:   adaOp = {{2{regs.ar[0]}}, regs.ar};
      adaARX:  adaOp = {{2{regs.arx[0]}}, regs.arx};
      adaMQ:   adaOp = {{2{regs.mq[0]}}, regs.mq};
      default: adaOp = '0;
    endcase
    adxaOp = (micro.ada == adaZero) ? '0 : regs.arx;
  end

  // ADB and ADXB muxes, doubled forms borrow from BRX/ARX
  always_comb begin
    case (micro.adb)
      adbFM: begin
        adbOp = {{2{fmData[0]}}, fmData};
        // No magic number field, ADX side gets zero
        adxbOp = '0;
      end
      adbBRx2: begin
        adbOp = {{2{regs.br[0]}}, regs.br[1:35], regs.brx[0]};
        adxbOp = {regs.brx[1:35], 1'b0};
      end
      adbBR: begin
        adbOp = {{2{regs.br[0]}}, regs.br};
        adxbOp = regs.brx;
      end
      default: begin
        adbOp = {regs.ar, regs.arx[0:1]};
        adxbOp = {regs.arx[2:35], 2'b00};
      end
    endcase
  end

  // Arithmetic path
  always_comb begin
    subtract = (micro.adFunc == fnSub);
    arith = (micro.adFunc == fnAdd) || subtract;
    adbEff = subtract ? ~adbOp : adbOp;
    adxbEff = subtract ? ~adxbOp : adxbOp;

    adxCin = micro.cryIn | subtract;
    adxSum = {1'b0, adxaOp} + {1'b0, adxbEff} + 37'(adxCin);

    // Long ops link ADX carry out into AD
    if (micro.adLong) begin
      adCin = adxSum[0];
    end else begin
      adCin = subtract | micro.cryIn;
    end

    adSum = adaOp + adbEff + 38'(adCin);
    adLow = {1'b0, adaOp[2:37]} + {1'b0, adbEff[2:37]} + 37'(adCin);
  end

  // Function select, booleans have no carries
  always_comb begin
    carryOut = 1'b0;
    case (micro.adFunc)
      fnAnd: begin
        adFull = adaOp & adbOp;
        adxFull = adxaOp & adxbOp;
      end
      fnOr: begin
        adFull = adaOp | adbOp;
        adxFull = adxaOp | adxbOp;
      end
      fnXor: begin
        adFull = adaOp ^ adbOp;
        adxFull = adxaOp ^ adxbOp;
      end
      fnPassA: begin
        adFull = adaOp;
        adxFull = adxaOp;
      end
      fnPassB: begin
        adFull = adbOp;
        adxFull = adxbOp;
      end
      fnSetOnes: begin
        adFull = '1;
        adxFull = '1;
      end
      default: begin
        adFull = adSum;
        adxFull = adxSum[1:36];
        carryOut = arith & adLow[0];
      end
    endcase
  end

  assign result.ad = adFull[2:37];
  assign result.adEx = adFull[0:1];
  assign result.adx = adxFull;
  assign result.adCarry = carryOut;
  // Sign and bit -1 disagree on overflow
  assign result.adOverflow = adFull[1] ^ adFull[2];

endmodule

//--- edp/fastMem.sv
`timescale 1ns/1ps

module fastMem(
  input  logic CLK,
  input  logic [0:edpPkg::fmAddrWidth-1] fmAdr,
  input  logic writeL,
  input  logic writeR,
  input  edpPkg::word36 wrData,
  output edpPkg::word36 rdData,
  output logic parity
);
  import edpPkg::*;

  // Accumulator words, contents undefined until written
  word36 mem [fmWords];

  // Halfword write enables
  always_ff @(posedge CLK) begin
    if (writeL) begin
      mem[fmAdr][0:17] <= wrData[0:17];
    end
    if (writeR) begin
      mem[fmAdr][18:35] <= wrData[18:35];
    end
  end

  // Read is asynchronous
  assign rdData = mem[fmAdr];

  // Even parity, word plus this bit has an even count of ones
  assign parity = ^rdData;

endmodule

//--- logic/ebusDiag.sv
`timescale 1ns/1ps

module ebusDiag(
  input  logic CLK,
  input  logic reset,
  input  logic diagLoad,
  input  edpPkg::diagFunc_e diagCode,
  input  logic diagRead,
  input  logic adToEbusL,
  input  logic adToEbusR,
  input  edpPkg::regFile regs,
  input  edpPkg::adResult ad,
  input  edpPkg::word36 fmData,
  output edpPkg::word36 ebusData,
  output logic ebusDriving
);
  import edpPkg::*;

  diagFunc_e diagFunc;
  diagFunc_e srcFunc;
  word36 srcWord;
  half18 leftHalf;
  half18 rightHalf;
  logic driveL;
  logic driveR;

  // Diagnostic function register
  always_ff @(posedge CLK) begin
    if (reset) begin
      diagFunc <= dAR;
    end else if (diagLoad) begin
      diagFunc <= diagCode;
    end
  end

  always_comb begin
    driveL = adToEbusL | diagRead;
    driveR = adToEbusR | diagRead;
    // Any AD to EBUS request forces AD as the source
    srcFunc = (adToEbusL | adToEbusR) ? dAD : diagFunc;
    case (srcFunc)
      dAR:     srcWord = regs.ar;
      dBR:     srcWord = regs.br;
      dMQ:     srcWord = regs.mq;
      dFM:     srcWord = fmData;
      dBRX:    srcWord = regs.brx;
      dARX:    srcWord = regs.arx;
      dADX:    srcWord = ad.adx;
      default: srcWord = ad.ad;
    endcase
    leftHalf = driveL ? srcWord[0:17] : '0;
    rightHalf = driveR ? srcWord[18:35] : '0;
  end

  // Readout lands one edge after the request
  always_ff @(posedge CLK) begin
    if (reset) begin
      ebusDriving <= 1'b0;
      ebusData <= '0;
    end else begin
      ebusDriving <= driveL | driveR;
      ebusData <= {leftHalf, rightHalf};
    end
  end

endmodule

//--- edp/edp.sv
`timescale 1ns/1ps

module edp(
  input  logic CLK,
  input  logic reset,
  input  edpPkg::ebMicro micro,
  input  edpPkg::word36 cacheData,
  input  logic diagLoad,
  input  edpPkg::diagFunc_e diagCode,
  input  logic diagRead,
  output edpPkg::word36 ad,
  output logic adCarry,
  output logic adOverflow,
  output logic fmParity,
  output edpPkg::word36 ebusData,
  output logic ebusDriving
);
  import edpPkg::*;

  regFile regs;
  adResult adRes;
  word36 fmData;

  edpRegs regs0(
    .CLK(CLK),
    .reset(reset),
    .micro(micro),
    .cacheData(cacheData),
    .ad(adRes),
    .regs(regs)
  );

  edpAdder adder0(
    .micro(micro),
    .regs(regs),
    .fmData(fmData),
    .result(adRes)
  );

  // Fast memory always writes from AR
  fastMem fm0(
    .CLK(CLK),
    .fmAdr(micro.fmAdr),
    .writeL(micro.fmWriteL),
    .writeR(micro.fmWriteR),
    .wrData(regs.ar),
    .rdData(fmData),
    .parity(fmParity)
  );

  ebusDiag ebus0(
    .CLK(CLK),
    .reset(reset),
    .diagLoad(diagLoad),
    .diagCode(diagCode),
    .diagRead(diagRead),
    .adToEbusL(micro.adToEbusL),
    .adToEbusR(micro.adToEbusR),
    .regs(regs),
    .ad(adRes),
    .fmData(fmData),
    .ebusData(ebusData),
    .ebusDriving(ebusDriving)
  );

  assign ad = adRes.ad;
  assign adCarry = adRes.adCarry;
  assign adOverflow = adRes.adOverflow;

endmodule

//--- bench/edpVectors.svh
// Table rows in run order: stimulus first, then expected values for that row
task automatic buildTable();
  ebMicro m;
  word36 rA;
  word36 rB;
  word36 maxPos;
  word36 ones;
  word36 fmWord;
  word36 mqVal;
  logic [0:37] r;
  logic [0:37] rx;
  nextWord(rA);
  nextWord(rB);
  maxPos = {1'b0, {35{1'b1}}};
  ones = '1;

  // Readout after reset
  m = idleMicro();
  addRow("rdAR0", m, '0);
  setDiag(1'b0, dAR, 1'b1);
  expectAd('0, 1'b0, 1'b0);
  expectEbus(1'b1, '0);
  addRow("selBR0", m, '0);
  setDiag(1'b1, dBR, 1'b0);
  expectEbus(1'b0, '0);
  addRow("rdBR0", m, '0);
  setDiag(1'b0, dBR, 1'b1);
  expectEbus(1'b1, '0);
  addRow("selMQ0", m, '0);
  setDiag(1'b1, dMQ, 1'b0);
  addRow("rdMQ0", m, '0);
  setDiag(1'b0, dMQ, 1'b1);
  expectEbus(1'b1, '0);

  // AR load, then BR captures the old AR
  m.arlSel = srcCache;
  m.arrSel = srcCache;
  addRow("ldAR", m, rA);
  m.brLoad = 1'b1;
  addRow("ldARandBR", m, rB);
  m = idleMicro();
  addRow("selAR", m, '0);
  setDiag(1'b1, dAR, 1'b0);
  addRow("rdAR", m, '0);
  setDiag(1'b0, dAR, 1'b1);
  expectAd(rB, 1'b0, 1'b0);
  expectEbus(1'b1, rB);
  addRow("selBR", m, '0);
  setDiag(1'b1, dBR, 1'b0);
  addRow("rdBR", m, '0);
  setDiag(1'b0, dBR, 1'b1);
  expectEbus(1'b1, rA);
  m.adToEbusL = 1'b1;
  addRow("adEbusLeft", m, '0);
  expectEbus(1'b1, {rB[0:17], 18'h0});
  m.adToEbusL = 1'b0;

  // Adder functions, AR is rB and BR is rA
  m.adFunc = fnAdd;
  r = addModel(rB, rA, 1'b0, 1'b0);
  addRow("add", m, '0);
  expectAd(r[2:37], r[0], r[1]);
  m.adFunc = fnSub;
  r = addModel(rB, rA, 1'b0, 1'b1);
  addRow("sub", m, '0);
  expectAd(r[2:37], r[0], r[1]);
  m.adFunc = fnAnd;
  addRow("and", m, '0);
  expectAd(rB & rA, 1'b0, 1'b0);
  m.adFunc = fnOr;
  addRow("or", m, '0);
  expectAd(rB | rA, 1'b0, 1'b0);
  m.adFunc = fnXor;
  addRow("xor", m, '0);
  expectAd(rB ^ rA, 1'b0, 1'b0);
  m.adFunc = fnPassB;
  addRow("passB", m, '0);
  expectAd(rA, 1'b0, 1'b0);
  m.adFunc = fnSetOnes;
  addRow("setOnes", m, '0);
  expectAd(ones, 1'b0, 1'b0);

  // Most positive plus one
  m = idleMicro();
  m.arlSel = srcCache;
  m.arrSel = srcCache;
  addRow("ldMax", m, maxPos);
  m.arlSel = srcZero;
  m.arrSel = srcZero;
  m.brLoad = 1'b1;
  addRow("zeroARmaxBR", m, '0);
  m = idleMicro();
  m.adFunc = fnAdd;
  m.cryIn = 1'b1;
  r = addModel('0, maxPos, 1'b1, 1'b0);
  addRow("maxPlusOne", m, '0);
  expectAd(r[2:37], r[0], r[1]);

  // Long add, ARX and BRX all ones so ADX carries out
  m = idleMicro();
  m.arxSel = srcCache;
  addRow("ldARX", m, ones);
  m = idleMicro();
  m.brxLoad = 1'b1;
  addRow("ldBRX", m, '0);
  m = idleMicro();
  m.adFunc = fnAdd;
  m.adLong = 1'b1;
  rx = addModel(ones, ones, 1'b0, 1'b0);
  r = addModel('0, maxPos, rx[0], 1'b0);
  addRow("longCarry", m, '0);
  expectAd(r[2:37], r[0], r[1]);
  m.adLong = 1'b0;
  r = addModel('0, maxPos, 1'b0, 1'b0);
  addRow("shortNoCarry", m, '0);
  expectAd(r[2:37], r[0], r[1]);

  // Fast memory halfword writes at word 3
  m = idleMicro();
  m.arlSel = srcCache;
  m.arrSel = srcCache;
  addRow("ldARfm", m, rA);
  m = idleMicro();
  m.fmAdr = 4'd3;
  m.fmWriteL = 1'b1;
  m.fmWriteR = 1'b1;
  addRow("fmWrite", m, '0);
  m = idleMicro();
  m.fmAdr = 4'd3;
  m.ada = adaZero;
  m.adb = adbFM;
  m.adFunc = fnPassB;
  m.arlSel = srcCache;
  m.arrSel = srcCache;
  addRow("fmRead", m, rB);
  expectAd(rA, 1'b0, 1'b0);
  expectPar(^rA);
  m.arlSel = srcHold;
  m.arrSel = srcHold;
  m.fmWriteL = 1'b1;
  addRow("fmWriteL", m, '0);
  expectPar(^rA);
  m.fmWriteL = 1'b0;
  fmWord = {rB[0:17], rA[18:35]};
  addRow("fmReadL", m, '0);
  setDiag(1'b1, dFM, 1'b0);
  expectAd(fmWord, 1'b0, 1'b0);
  expectPar(^fmWord);
  m.fmWriteR = 1'b1;
  addRow("fmWriteR", m, '0);
  expectPar(^fmWord);
  m.fmWriteR = 1'b0;
  addRow("fmReadR", m, '0);
  setDiag(1'b0, dFM, 1'b1);
  expectAd(rB, 1'b0, 1'b0);
  expectPar(^rB);
  expectEbus(1'b1, rB);

  // MQ load and shifts, ARX and BRX all ones, BR is maxPos
  // Loaded bits 1 and 2 differ so the right shift shows which bit refills the top
  mqVal = {rB[0], 2'b01, rB[3:35]};
  m = idleMicro();
  m.arlSel = srcCache;
  m.arrSel = srcCache;
  addRow("ldARmq", m, mqVal);
  m = idleMicro();
  m.mqFunc = mqLoadAD;
  addRow("mqLoad", m, '0);
  setDiag(1'b1, dMQ, 1'b0);
  expectAd(mqVal, 1'b0, 1'b0);
  m = idleMicro();
  addRow("rdMQload", m, '0);
  setDiag(1'b0, dMQ, 1'b1);
  expectEbus(1'b1, mqVal);
  // ARX plus maxPos always carries out
  m.ada = adaARX;
  m.adFunc = fnAdd;
  m.mqFunc = mqShl;
  r = addModel(ones, maxPos, 1'b0, 1'b0);
  mqVal = {mqVal[1:35], r[0]};
  addRow("mqShl", m, '0);
  expectAd(r[2:37], r[0], r[1]);
  m = idleMicro();
  addRow("rdMQshl", m, '0);
  setDiag(1'b0, dMQ, 1'b1);
  expectEbus(1'b1, mqVal);
  m.mqFunc = mqShr;
  mqVal = {mqVal[1], mqVal[0:34]};
  addRow("mqShr", m, '0);
  m = idleMicro();
  addRow("rdMQshr", m, '0);
  setDiag(1'b0, dMQ, 1'b1);
  expectEbus(1'b1, mqVal);
endtask

//--- bench/edpTb.sv
`timescale 1ns/1ps

module edpTb;
  import edpPkg::*;

  localparam int clkPeriod = 100;
  localparam int resetCycles = 8;

  typedef struct {
    string name;
    ebMicro micro;
    word36 cache;
    logic diagLoad;
    diagFunc_e diagCode;
    logic diagRead;
    logic chkAd;
    word36 expAd;
    logic expCarry;
    logic expOvf;
    logic chkPar;
    logic expPar;
    logic chkEbus;
    logic expDriving;
    word36 expEbus;
  } row_t;

  logic CLK;
  logic reset;
  ebMicro micro;
  word36 cacheData;
  logic diagLoad;
  diagFunc_e diagCode;
  logic diagRead;
  word36 ad;
  logic adCarry;
  logic adOverflow;
  logic fmParity;
  word36 ebusData;
  logic ebusDriving;

  row_t rows[$];
  logic [31:0] lfsr = 32'heee;
  int errors = 0;
  logic tableReady = 1'b0;

  edp dut0(
    .CLK(CLK),
    .reset(reset),
    .micro(micro),
    .cacheData(cacheData),
    .diagLoad(diagLoad),
    .diagCode(diagCode),
    .diagRead(diagRead),
    .ad(ad),
    .adCarry(adCarry),
    .adOverflow(adOverflow),
    .fmParity(fmParity),
    .ebusData(ebusData),
    .ebusDriving(ebusDriving)
  );

  initial begin
    CLK = 1'b0;
    forever #(clkPeriod / 2) CLK = ~CLK;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  task automatic nextWord(output word36 w);
    logic fb;
    for (int i = 0; i < 36; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      w[i] = fb;
    end
  endtask

  // Returns carry, overflow and the 36-bit sum
  function automatic logic [0:37] addModel(word36 a, word36 b, logic cin, logic sub);
    word36 bb;
    logic c;
    logic [0:36] s;
    logic ovf;
    bb = sub ? ~b : b;
    c = sub ? 1'b1 : cin;
    s = {1'b0, a} + {1'b0, bb} + 37'(c);
    ovf = (a[0] == bb[0]) && (s[1] != a[0]);
    return {s[0], ovf, s[1:36]};
  endfunction

  function automatic ebMicro idleMicro();
    ebMicro m;
    m = '0;
    m.ada = adaAR;
    m.adb = adbBR;
    m.adFunc = fnPassA;
    m.mqFunc = mqHold;
    return m;
  endfunction

  task automatic addRow(string name, ebMicro m, word36 cache);
    row_t r;
    r = '{name: name, micro: m, cache: cache, diagCode: dAR, expAd: '0, expEbus: '0,
          default: 1'b0};
    rows.push_back(r);
  endtask

  task automatic setDiag(logic load, diagFunc_e code, logic rd);
    rows[rows.size()-1].diagLoad = load;
    rows[rows.size()-1].diagCode = code;
    rows[rows.size()-1].diagRead = rd;
  endtask

  task automatic expectAd(word36 value, logic carry, logic ovf);
    rows[rows.size()-1].chkAd = 1'b1;
    rows[rows.size()-1].expAd = value;
    rows[rows.size()-1].expCarry = carry;
    rows[rows.size()-1].expOvf = ovf;
  endtask

  task automatic expectPar(logic p);
    rows[rows.size()-1].chkPar = 1'b1;
    rows[rows.size()-1].expPar = p;
  endtask

  task automatic expectEbus(logic drv, word36 value);
    rows[rows.size()-1].chkEbus = 1'b1;
    rows[rows.size()-1].expDriving = drv;
    rows[rows.size()-1].expEbus = value;
  endtask

  `include "edpVectors.svh"

  task automatic compareVal(string name, string field, logic [35:0] expected,
                            logic [35:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s.%s expected %h actual %h", name, field, expected, actual);
    end
  endtask

  task automatic checkEbus(row_t r);
    compareVal(r.name, "ebusDriving", 36'(r.expDriving), 36'(ebusDriving));
    compareVal(r.name, "ebusData", r.expEbus, ebusData);
  endtask

  // Watchdog sized from the table length
  initial begin
    longint limit;
    wait (tableReady);
    limit = longint'(rows.size() + resetCycles) * 2 * clkPeriod;
    #(limit);
    $display("Timeout, the run did not finish in %0d ns", limit);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    reset = 1'b1;
    micro = idleMicro();
    cacheData = '0;
    diagLoad = 1'b0;
    diagCode = dAR;
    diagRead = 1'b0;
    buildTable();
    tableReady = 1'b1;

    repeat (resetCycles) @(posedge CLK);
    reset <= 1'b0;
    @(negedge CLK);
    compareVal("afterReset", "ebusDriving", 36'd0, 36'(ebusDriving));
    compareVal("afterReset", "ebusData", 36'd0, ebusData);

    for (int i = 0; i < rows.size(); i++) begin
      @(posedge CLK);
      micro <= rows[i].micro;
      cacheData <= rows[i].cache;
      diagLoad <= rows[i].diagLoad;
      diagCode <= rows[i].diagCode;
      diagRead <= rows[i].diagRead;
      @(negedge CLK);
      if (rows[i].chkAd) begin
        compareVal(rows[i].name, "ad", rows[i].expAd, ad);
        compareVal(rows[i].name, "adCarry", 36'(rows[i].expCarry), 36'(adCarry));
        compareVal(rows[i].name, "adOverflow", 36'(rows[i].expOvf), 36'(adOverflow));
      end
      if (rows[i].chkPar) begin
        compareVal(rows[i].name, "fmParity", 36'(rows[i].expPar), 36'(fmParity));
      end
      // EBUS shows the previous row's request
      if (i > 0 && rows[i-1].chkEbus) begin
        checkEbus(rows[i-1]);
      end
    end

    @(posedge CLK);
    micro <= idleMicro();
    diagLoad <= 1'b0;
    diagRead <= 1'b0;
    @(negedge CLK);
    if (rows[rows.size()-1].chkEbus) begin
      checkEbus(rows[rows.size()-1]);
    end

    $display("Rows run %0d, errors %0d", rows.size(), errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+bench
common/edpPkg.sv
edp/edpRegs.sv
edp/edpAdder.sv
edp/fastMem.sv
logic/ebusDiag.sv
edp/edp.sv
bench/edpTb.sv

//--- run.sh
#!/bin/sh
# Build and run the EDP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module edpTb -Mdir obj_dir -o edpSim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/edpSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -Fxq '** PASS **' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
